/* hw/fetch_pkg.sv */
package fetch_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Instruction and address width
    localparam int XLEN = 32;

    // Instruction buffer geometry
    localparam int BUF_DEPTH = 16;
    localparam int BUF_PTR_W = 4;
    localparam int BUF_CNT_W = BUF_PTR_W + 1;

    localparam logic [BUF_PTR_W-1:0] BUF_PTR_ONE = BUF_PTR_W'(1);

    // Highest occupancy that still leaves room for a full pair
    localparam logic [BUF_CNT_W-1:0] BUF_TWO_FREE_MAX = BUF_CNT_W'(BUF_DEPTH - 2);

    ////////////////////
    // Addresses
    ////////////////////

    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam logic [XLEN-1:0] WORD_BYTES = XLEN'(4);
    localparam logic [XLEN-1:0] PAIR_BYTES = XLEN'(8);

    ////////////////////
    // Encodings
    ////////////////////

    // Direct branch, 26-bit word offset
    localparam logic [5:0] OPC_B = 6'b010100;
    // Indirect jump through rj
    localparam logic [5:0] OPC_JR = 6'b010011;

    // One instruction word, seen as register or branch format
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rd;
            logic [4:0]  rj;
            logic [4:0]  rk;
            logic [10:0] func;
        } alu_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] offs;
        } br_fmt;
    } inst_word_u;

endpackage

/* hw/fetch_pc_gen.sv */
module fetch_pc_gen (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       req_ready_i,
    input  logic                       resp_valid_i,
    input  logic                       redirect_i,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
    input  logic                       pred_redirect_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,
    input  logic                       buf_two_free_i,
    output logic                       req_valid_o,
    output logic [fetch_pkg::XLEN-1:0] req_pc_o,
    output logic                       resp_accept_o,
    output logic [fetch_pkg::XLEN-1:0] resp_pc_o
);

    // Next fetch PC, may point at the second word of a pair
    logic [fetch_pkg::XLEN-1:0] fetch_pc_q;
    // PC of the request in flight
    logic [fetch_pkg::XLEN-1:0] pair_pc_q;
    logic [fetch_pkg::XLEN-1:0] pair_base;
    logic                       req_pending_q;
    logic                       stale_q;
    logic                       req_fire;

    ////////////////////
    // Request side
    ////////////////////

    // One request in flight, and only with room for a whole pair
    assign req_valid_o = !req_pending_q && buf_two_free_i && !redirect_i;
    assign req_pc_o    = {fetch_pc_q[fetch_pkg::XLEN-1:3], 3'b000};
    assign req_fire    = req_valid_o && req_ready_i;

    ////////////////////
    // Response side
    ////////////////////

    // Responses to a pre-redirect request are dropped
    assign resp_accept_o = resp_valid_i && req_pending_q && !stale_q && !redirect_i;
    assign resp_pc_o     = pair_pc_q;
    assign pair_base     = {pair_pc_q[fetch_pkg::XLEN-1:3], 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_pending_q <= 1'b0;
            stale_q       <= 1'b0;
        end else if (req_fire) begin
            req_pending_q <= 1'b1;
            stale_q       <= 1'b0;
        end else if (resp_valid_i && req_pending_q) begin
            req_pending_q <= 1'b0;
            stale_q       <= 1'b0;
        end else if (redirect_i && req_pending_q) begin
            stale_q <= 1'b1;
        end
    end

    // Back-end redirect wins over a predicted-taken branch
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fetch_pc_q <= fetch_pkg::RESET_PC;
        end else if (redirect_i) begin
            fetch_pc_q <= redirect_pc_i;
        end else if (pred_redirect_i) begin
            fetch_pc_q <= pred_target_i;
        end else if (resp_accept_o) begin
            fetch_pc_q <= pair_base + fetch_pkg::PAIR_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            pair_pc_q <= fetch_pc_q;
        end
    end

endmodule

/* hw/fetch_predecode.sv */
module fetch_predecode (
    input  logic                       resp_accept_i,
    input  logic [fetch_pkg::XLEN-1:0] resp_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] resp_inst0_i,
    input  logic [fetch_pkg::XLEN-1:0] resp_inst1_i,
    output logic                       push0_valid_o,
    output logic [fetch_pkg::XLEN-1:0] push0_inst_o,
    output logic [fetch_pkg::XLEN-1:0] push0_pc_o,
    output logic                       push0_is_branch_o,
    output logic                       push0_pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] push0_pred_target_o,
    output logic                       push1_valid_o,
    output logic [fetch_pkg::XLEN-1:0] push1_inst_o,
    output logic [fetch_pkg::XLEN-1:0] push1_pc_o,
    output logic                       push1_is_branch_o,
    output logic                       push1_pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] push1_pred_target_o,
    output logic                       pred_redirect_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o
);

    logic [fetch_pkg::XLEN-1:0] pair_base;
    logic [fetch_pkg::XLEN-1:0] pc1;
    // {is_branch, pred_taken, pred_target} per word
    logic [fetch_pkg::XLEN+1:0] info0;
    logic [fetch_pkg::XLEN+1:0] info1;
    logic                       skip0;

    // Static rule: backward direct branches taken, everything else not taken
    function automatic logic [fetch_pkg::XLEN+1:0] predict(
        input fetch_pkg::inst_word_u       word,
        input logic [fetch_pkg::XLEN-1:0] pc
    );
        logic [fetch_pkg::XLEN-1:0] offs_ext;
        offs_ext = {{(fetch_pkg::XLEN-28){word.br_fmt.offs[25]}}, word.br_fmt.offs, 2'b00};
        if (word.br_fmt.opcode == fetch_pkg::OPC_B) begin
            predict = {1'b1, word.br_fmt.offs[25], pc + offs_ext};
        end else if (word.alu_fmt.opcode == fetch_pkg::OPC_JR) begin
            // Register target, returns included, unknown here
            predict = {2'b10, {fetch_pkg::XLEN{1'b0}}};
        end else begin
            predict = '0;
        end
    endfunction

    assign pair_base = {resp_pc_i[fetch_pkg::XLEN-1:3], 3'b000};
    assign pc1       = pair_base + fetch_pkg::WORD_BYTES;
    // Target landed on the second word, first word is not on the path
    assign skip0     = resp_pc_i[2];
    assign info0     = predict(resp_inst0_i, pair_base);
    assign info1     = predict(resp_inst1_i, pc1);

    assign push1_inst_o        = resp_inst1_i;
    assign push1_pc_o          = pc1;
    assign push1_is_branch_o   = info1[fetch_pkg::XLEN+1];
    assign push1_pred_taken_o  = info1[fetch_pkg::XLEN];
    assign push1_pred_target_o = info1[fetch_pkg::XLEN-1:0];

    always_comb begin
        push0_valid_o = resp_accept_i;
        if (skip0) begin
            push0_inst_o        = resp_inst1_i;
            push0_pc_o          = pc1;
            push0_is_branch_o   = info1[fetch_pkg::XLEN+1];
            push0_pred_taken_o  = info1[fetch_pkg::XLEN];
            push0_pred_target_o = info1[fetch_pkg::XLEN-1:0];
            push1_valid_o       = 1'b0;
            pred_redirect_o     = resp_accept_i && info1[fetch_pkg::XLEN];
            pred_target_o       = info1[fetch_pkg::XLEN-1:0];
        end else begin
            push0_inst_o        = resp_inst0_i;
            push0_pc_o          = pair_base;
            push0_is_branch_o   = info0[fetch_pkg::XLEN+1];
            push0_pred_taken_o  = info0[fetch_pkg::XLEN];
            push0_pred_target_o = info0[fetch_pkg::XLEN-1:0];
            // Taken slot 0 cuts off the rest of the pair
            push1_valid_o       = resp_accept_i && !info0[fetch_pkg::XLEN];
            pred_redirect_o     = resp_accept_i
                                  && (info0[fetch_pkg::XLEN] || info1[fetch_pkg::XLEN]);
            pred_target_o       = info0[fetch_pkg::XLEN] ? info0[fetch_pkg::XLEN-1:0]
                                                         : info1[fetch_pkg::XLEN-1:0];
        end
    end

endmodule

/* hw/inst_buffer.sv */
module inst_buffer (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       push0_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] push0_inst_i,
    input  logic [fetch_pkg::XLEN-1:0] push0_pc_i,
    input  logic                       push0_is_branch_i,
    input  logic                       push0_pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] push0_pred_target_i,
    input  logic                       push1_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] push1_inst_i,
    input  logic [fetch_pkg::XLEN-1:0] push1_pc_i,
    input  logic                       push1_is_branch_i,
    input  logic                       push1_pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] push1_pred_target_i,
    input  logic                       issue_ready_i,
    output logic                       buf_two_free_o,
    output logic                       slot0_valid_o,
    output logic [fetch_pkg::XLEN-1:0] slot0_inst_o,
    output logic [fetch_pkg::XLEN-1:0] slot0_pc_o,
    output logic                       slot0_is_branch_o,
    output logic                       slot0_pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] slot0_pred_target_o,
    output logic                       slot1_valid_o,
    output logic [fetch_pkg::XLEN-1:0] slot1_inst_o,
    output logic [fetch_pkg::XLEN-1:0] slot1_pc_o,
    output logic                       slot1_is_branch_o,
    output logic                       slot1_pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] slot1_pred_target_o
);

    ////////////////////
    // Storage
    ////////////////////

    logic [fetch_pkg::XLEN-1:0]      inst_mem [fetch_pkg::BUF_DEPTH];
    logic [fetch_pkg::XLEN-1:0]      pc_mem [fetch_pkg::BUF_DEPTH];
    logic [fetch_pkg::XLEN-1:0]      target_mem [fetch_pkg::BUF_DEPTH];
    logic [fetch_pkg::BUF_DEPTH-1:0] is_branch_mem;
    logic [fetch_pkg::BUF_DEPTH-1:0] taken_mem;

    logic [fetch_pkg::BUF_PTR_W-1:0] head_q;
    logic [fetch_pkg::BUF_PTR_W-1:0] tail_q;
    logic [fetch_pkg::BUF_PTR_W-1:0] head_p1;
    logic [fetch_pkg::BUF_PTR_W-1:0] tail_p1;
    logic [fetch_pkg::BUF_PTR_W-1:0] push1_idx;
    logic [fetch_pkg::BUF_CNT_W-1:0] count_q;
    // Entries written and removed this cycle
    logic [fetch_pkg::BUF_PTR_W-1:0] push_n;
    logic [fetch_pkg::BUF_PTR_W-1:0] pop_n;

    assign head_p1   = head_q + fetch_pkg::BUF_PTR_ONE;
    assign tail_p1   = tail_q + fetch_pkg::BUF_PTR_ONE;
    // A lone push1 still lands at the tail
    assign push1_idx = push0_valid_i ? tail_p1 : tail_q;

    assign push_n = {{(fetch_pkg::BUF_PTR_W-1){1'b0}}, push0_valid_i}
                  + {{(fetch_pkg::BUF_PTR_W-1){1'b0}}, push1_valid_i};
    assign pop_n  = issue_ready_i ? ({{(fetch_pkg::BUF_PTR_W-1){1'b0}}, slot0_valid_o}
                                   + {{(fetch_pkg::BUF_PTR_W-1){1'b0}}, slot1_valid_o})
                                  : '0;

    assign buf_two_free_o = (count_q <= fetch_pkg::BUF_TWO_FREE_MAX);

    ////////////////////
    // Show-ahead slots
    ////////////////////

    assign slot0_valid_o = |count_q;
    assign slot1_valid_o = |count_q[fetch_pkg::BUF_CNT_W-1:1];

    assign slot0_inst_o        = inst_mem[head_q];
    assign slot0_pc_o          = pc_mem[head_q];
    assign slot0_is_branch_o   = is_branch_mem[head_q];
    assign slot0_pred_taken_o  = taken_mem[head_q];
    assign slot0_pred_target_o = target_mem[head_q];

    assign slot1_inst_o        = inst_mem[head_p1];
    assign slot1_pc_o          = pc_mem[head_p1];
    assign slot1_is_branch_o   = is_branch_mem[head_p1];
    assign slot1_pred_taken_o  = taken_mem[head_p1];
    assign slot1_pred_target_o = target_mem[head_p1];

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + pop_n;
            tail_q  <= tail_q + push_n;
            count_q <= count_q + {1'b0, push_n} - {1'b0, pop_n};
        end
    end

    // Entry writes, at most two per cycle
    always_ff @(posedge clk) begin
        if (push0_valid_i && !flush_i) begin
            inst_mem[tail_q]      <= push0_inst_i;
            pc_mem[tail_q]        <= push0_pc_i;
            target_mem[tail_q]    <= push0_pred_target_i;
            is_branch_mem[tail_q] <= push0_is_branch_i;
            taken_mem[tail_q]     <= push0_pred_taken_i;
        end
        if (push1_valid_i && !flush_i) begin
            inst_mem[push1_idx]      <= push1_inst_i;
            pc_mem[push1_idx]        <= push1_pc_i;
            target_mem[push1_idx]    <= push1_pred_target_i;
            is_branch_mem[push1_idx] <= push1_is_branch_i;
            taken_mem[push1_idx]     <= push1_pred_taken_i;
        end
    end

endmodule

/* hw/fetch_top.sv */
module fetch_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    output logic                       req_valid_o,
    output logic [fetch_pkg::XLEN-1:0] req_pc_o,
    input  logic                       req_ready_i,
    input  logic                       resp_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] resp_inst0_i,
    input  logic [fetch_pkg::XLEN-1:0] resp_inst1_i,
    input  logic                       redirect_i,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
    input  logic                       issue_ready_i,
    output logic                       slot0_valid_o,
    output logic [fetch_pkg::XLEN-1:0] slot0_inst_o,
    output logic [fetch_pkg::XLEN-1:0] slot0_pc_o,
    output logic                       slot0_is_branch_o,
    output logic                       slot0_pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] slot0_pred_target_o,
    output logic                       slot1_valid_o,
    output logic [fetch_pkg::XLEN-1:0] slot1_inst_o,
    output logic [fetch_pkg::XLEN-1:0] slot1_pc_o,
    output logic                       slot1_is_branch_o,
    output logic                       slot1_pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] slot1_pred_target_o
);

    logic                       resp_accept;
    logic [fetch_pkg::XLEN-1:0] resp_pc;
    logic                       pred_redirect;
    logic [fetch_pkg::XLEN-1:0] pred_target;
    logic                       buf_two_free;

    // Predecode to buffer
    logic                       push0_valid;
    logic [fetch_pkg::XLEN-1:0] push0_inst;
    logic [fetch_pkg::XLEN-1:0] push0_pc;
    logic                       push0_is_branch;
    logic                       push0_pred_taken;
    logic [fetch_pkg::XLEN-1:0] push0_pred_target;
    logic                       push1_valid;
    logic [fetch_pkg::XLEN-1:0] push1_inst;
    logic [fetch_pkg::XLEN-1:0] push1_pc;
    logic                       push1_is_branch;
    logic                       push1_pred_taken;
    logic [fetch_pkg::XLEN-1:0] push1_pred_target;

    fetch_pc_gen u_pc_gen (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_ready_i     (req_ready_i),
        .resp_valid_i    (resp_valid_i),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .pred_redirect_i (pred_redirect),
        .pred_target_i   (pred_target),
        .buf_two_free_i  (buf_two_free),
        .req_valid_o     (req_valid_o),
        .req_pc_o        (req_pc_o),
        .resp_accept_o   (resp_accept),
        .resp_pc_o       (resp_pc)
    );

    fetch_predecode u_predecode (
        .resp_accept_i       (resp_accept),
        .resp_pc_i           (resp_pc),
        .resp_inst0_i        (resp_inst0_i),
        .resp_inst1_i        (resp_inst1_i),
        .push0_valid_o       (push0_valid),
        .push0_inst_o        (push0_inst),
        .push0_pc_o          (push0_pc),
        .push0_is_branch_o   (push0_is_branch),
        .push0_pred_taken_o  (push0_pred_taken),
        .push0_pred_target_o (push0_pred_target),
        .push1_valid_o       (push1_valid),
        .push1_inst_o        (push1_inst),
        .push1_pc_o          (push1_pc),
        .push1_is_branch_o   (push1_is_branch),
        .push1_pred_taken_o  (push1_pred_taken),
        .push1_pred_target_o (push1_pred_target),
        .pred_redirect_o     (pred_redirect),
        .pred_target_o       (pred_target)
    );

    inst_buffer u_buf (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .flush_i             (redirect_i),
        .push0_valid_i       (push0_valid),
        .push0_inst_i        (push0_inst),
        .push0_pc_i          (push0_pc),
        .push0_is_branch_i   (push0_is_branch),
        .push0_pred_taken_i  (push0_pred_taken),
        .push0_pred_target_i (push0_pred_target),
        .push1_valid_i       (push1_valid),
        .push1_inst_i        (push1_inst),
        .push1_pc_i          (push1_pc),
        .push1_is_branch_i   (push1_is_branch),
        .push1_pred_taken_i  (push1_pred_taken),
        .push1_pred_target_i (push1_pred_target),
        .issue_ready_i       (issue_ready_i),
        .buf_two_free_o      (buf_two_free),
        .slot0_valid_o       (slot0_valid_o),
        .slot0_inst_o        (slot0_inst_o),
        .slot0_pc_o          (slot0_pc_o),
        .slot0_is_branch_o   (slot0_is_branch_o),
        .slot0_pred_taken_o  (slot0_pred_taken_o),
        .slot0_pred_target_o (slot0_pred_target_o),
        .slot1_valid_o       (slot1_valid_o),
        .slot1_inst_o        (slot1_inst_o),
        .slot1_pc_o          (slot1_pc_o),
        .slot1_is_branch_o   (slot1_is_branch_o),
        .slot1_pred_taken_o  (slot1_pred_taken_o),
        .slot1_pred_target_o (slot1_pred_target_o)
    );

endmodule

/* tb/fetch_props.sv */
module fetch_props (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       req_valid_o,
    input logic                       req_ready_i,
    input logic                       resp_valid_i,
    input logic                       redirect_i,
    input logic                       issue_ready_i,
    input logic                       slot0_valid_o,
    input logic [fetch_pkg::XLEN-1:0] slot0_inst_o,
    input logic [fetch_pkg::XLEN-1:0] slot0_pc_o,
    input logic                       slot1_valid_o,
    input logic [fetch_pkg::XLEN-1:0] slot1_pc_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Request in flight, seen from the bus
    logic outstanding_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (req_valid_o && req_ready_i) begin
            outstanding_q <= 1'b1;
        end else if (resp_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    slot1_needs_slot0: assert property (@(posedge clk) disable iff (!rst_n_i)
        slot1_valid_o |-> slot0_valid_o)
        else $error("slot1 valid without slot0");

    slot0_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
        slot0_valid_o && !issue_ready_i && !redirect_i
        |=> slot0_valid_o && $stable(slot0_inst_o) && $stable(slot0_pc_o))
        else $error("slot0 changed while stalled");

    slot1_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
        slot1_valid_o && !issue_ready_i && !redirect_i |=> slot1_valid_o && $stable(slot1_pc_o))
        else $error("slot1 changed while stalled");

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        outstanding_q |-> !req_valid_o)
        else $error("second request while one is outstanding");

endmodule

bind fetch_top fetch_props u_props (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_valid_o   (req_valid_o),
    .req_ready_i   (req_ready_i),
    .resp_valid_i  (resp_valid_i),
    .redirect_i    (redirect_i),
    .issue_ready_i (issue_ready_i),
    .slot0_valid_o (slot0_valid_o),
    .slot0_inst_o  (slot0_inst_o),
    .slot0_pc_o    (slot0_pc_o),
    .slot1_valid_o (slot1_valid_o),
    .slot1_pc_o    (slot1_pc_o)
);

/* tb/fetch_tb.sv */
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_COUNT  = 6;
    localparam int CYCLE_LIMIT = TEST_COUNT * 400;
    localparam int STREAM_LEN  = 24;

    logic                       clk;
    logic                       rst_n_i;
    logic                       req_valid_o;
    logic [fetch_pkg::XLEN-1:0] req_pc_o;
    logic                       req_ready_i;
    logic                       resp_valid_i;
    logic [fetch_pkg::XLEN-1:0] resp_inst0_i;
    logic [fetch_pkg::XLEN-1:0] resp_inst1_i;
    logic                       redirect_i;
    logic [fetch_pkg::XLEN-1:0] redirect_pc_i;
    logic                       issue_ready_i;
    logic                       slot0_valid_o;
    logic [fetch_pkg::XLEN-1:0] slot0_inst_o;
    logic [fetch_pkg::XLEN-1:0] slot0_pc_o;
    logic                       slot0_is_branch_o;
    logic                       slot0_pred_taken_o;
    logic [fetch_pkg::XLEN-1:0] slot0_pred_target_o;
    logic                       slot1_valid_o;
    logic [fetch_pkg::XLEN-1:0] slot1_inst_o;
    logic [fetch_pkg::XLEN-1:0] slot1_pc_o;
    logic                       slot1_is_branch_o;
    logic                       slot1_pred_taken_o;
    logic [fetch_pkg::XLEN-1:0] slot1_pred_target_o;

    // Cache contents, one word per 4 bytes
    logic [fetch_pkg::XLEN-1:0] mem [512];
    // Expected issue stream
    logic [fetch_pkg::XLEN-1:0] exp_inst [$];
    logic [fetch_pkg::XLEN-1:0] exp_pc [$];
    logic [fetch_pkg::XLEN+1:0] exp_info [$];

    int          seed;
    int          cycles;
    int          got_n;
    int          fires;
    int          test_err;
    int          total_err;
    int          tests_run;
    int          tests_failed;
    string       cur_test;
    logic        cache_busy;
    logic [1:0]  lat_cnt;
    logic [31:0] cache_pc;
    logic [31:0] rnd;

    fetch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // Cache model
    ////////////////////

    always @(posedge clk) begin
        if (!rst_n_i) begin
            cache_busy   <= 1'b0;
            req_ready_i  <= 1'b0;
            resp_valid_i <= 1'b0;
        end else begin
            resp_valid_i <= 1'b0;
            rnd = $random(seed);
            if (cache_busy) begin
                if (lat_cnt == 2'd0) begin
                    resp_valid_i <= 1'b1;
                    resp_inst0_i <= mem[cache_pc[10:2]];
                    resp_inst1_i <= mem[cache_pc[10:2] + 9'd1];
                    cache_busy   <= 1'b0;
                end else begin
                    lat_cnt <= lat_cnt - 2'd1;
                end
            end else if (req_valid_o && req_ready_i) begin
                if (req_pc_o[2:0] !== 3'b000) begin
                    $display("%s: request PC %h is not pair aligned", cur_test, req_pc_o);
                    test_err++;
                end
                cache_busy  <= 1'b1;
                cache_pc    <= req_pc_o;
                lat_cnt     <= 2'(rnd % 32'd3);
                req_ready_i <= 1'b0;
            end else begin
                req_ready_i <= rnd[4];
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            fires <= 0;
        end else if (req_valid_o && req_ready_i) begin
            fires <= fires + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in %s, %0d instructions seen", cycles, cur_test,
                     got_n);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_inst(input fetch_pkg::inst_word_u exp, input fetch_pkg::inst_word_u act);
        if (exp !== act) begin
            $display("ERROR %s inst expected %h actual %h", cur_test, exp, act);
            test_err++;
        end
    endtask

    task automatic check_pc(input logic [fetch_pkg::XLEN-1:0] exp,
                            input logic [fetch_pkg::XLEN-1:0] act);
        if (exp !== act) begin
            $display("ERROR %s pc expected %h actual %h", cur_test, exp, act);
            test_err++;
        end
    endtask

    task automatic check_branch(input logic [fetch_pkg::XLEN+1:0] exp, input logic is_branch,
                                input logic taken, input logic [fetch_pkg::XLEN-1:0] target);
        if (exp !== {is_branch, taken, target}) begin
            $display("ERROR %s branch expected %h actual %h", cur_test, exp,
                     {is_branch, taken, target});
            test_err++;
        end
    endtask

    task automatic take_slot(input logic [31:0] inst, input logic [31:0] pc, input logic isb,
                             input logic tk, input logic [31:0] tgt);
        if (exp_pc.size() > 0) begin
            check_inst(exp_inst.pop_front(), inst);
            check_pc(exp_pc.pop_front(), pc);
            check_branch(exp_info.pop_front(), isb, tk, tgt);
            got_n++;
        end
    endtask

    // Decode side, every valid slot is taken while ready
    always @(posedge clk) begin
        if (rst_n_i && issue_ready_i) begin
            if (slot0_valid_o) begin
                take_slot(slot0_inst_o, slot0_pc_o, slot0_is_branch_o, slot0_pred_taken_o,
                          slot0_pred_target_o);
            end
            if (slot1_valid_o) begin
                take_slot(slot1_inst_o, slot1_pc_o, slot1_is_branch_o, slot1_pred_taken_o,
                          slot1_pred_target_o);
            end
        end
    end

    ////////////////////
    // Test helpers
    ////////////////////

    task automatic fill_mem();
        for (int i = 0; i < 512; i++) begin
            mem[i] = {6'h01, i[4:0], i[20:0] ^ 21'h15a5a};
        end
    endtask

    // Walk memory by the static prediction rules
    task automatic build_expected(input logic [31:0] start, input int n);
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] tgt;
        logic        isb;
        logic        tk;
        pc = start;
        exp_inst.delete();
        exp_pc.delete();
        exp_info.delete();
        repeat (n) begin
            w   = mem[pc[10:2]];
            isb = 1'b0;
            tk  = 1'b0;
            tgt = '0;
            if (w[31:26] == fetch_pkg::OPC_B) begin
                isb = 1'b1;
                tk  = w[25];
                // Word offset, signed
                tgt = pc + 32'($signed(w[25:0])) * 32'd4;
            end else if (w[31:26] == fetch_pkg::OPC_JR) begin
                isb = 1'b1;
            end
            exp_inst.push_back(w);
            exp_pc.push_back(pc);
            exp_info.push_back({isb, tk, tgt});
            pc = tk ? tgt : pc + 32'd4;
        end
    endtask

    task automatic start_test(input string name, input logic ready, input logic [31:0] start);
        cur_test = name;
        test_err = 0;
        got_n    = 0;
        exp_pc.delete();
        @(posedge clk);
        rst_n_i       <= 1'b0;
        issue_ready_i <= ready;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        if (slot0_valid_o || slot1_valid_o) begin
            $display("%s: slots are valid right after reset", name);
            test_err++;
        end
        build_expected(start, STREAM_LEN);
    endtask

    task automatic end_test();
        while (got_n < STREAM_LEN) begin
            @(posedge clk);
        end
        tests_run++;
        total_err += test_err;
        if (test_err == 0) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, test_err);
        end
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_sequential();
        fill_mem();
        start_test("sequential", 1'b1, 32'h0);
        end_test();
    endtask

    task automatic test_backpressure();
        fill_mem();
        start_test("backpressure", 1'b0, 32'h0);
        repeat (150) @(posedge clk);
        // Full buffer holds eight pairs
        if (fires != 8) begin
            $display("ERROR %s requests expected %0d actual %0d", cur_test, 8, fires);
            test_err++;
        end
        if (req_valid_o) begin
            $display("%s: request raised with a full buffer", cur_test);
            test_err++;
        end
        check_pc(32'h0, slot0_pc_o);
        check_pc(32'h4, slot1_pc_o);
        issue_ready_i <= 1'b1;
        end_test();
    endtask

    task automatic test_forward_branch();
        fill_mem();
        mem[2] = {fetch_pkg::OPC_B, 26'd5};
        mem[5] = {fetch_pkg::OPC_JR, 5'd0, 5'd1, 16'd0};
        start_test("forward_branch", 1'b1, 32'h0);
        end_test();
    endtask

    task automatic test_taken_slot0();
        fill_mem();
        mem[8] = {fetch_pkg::OPC_B, -26'sd6};
        start_test("taken_slot0", 1'b1, 32'h0);
        end_test();
    endtask

    task automatic test_taken_slot1();
        fill_mem();
        // Target lands on the second word of a pair
        mem[9] = {fetch_pkg::OPC_B, -26'sd6};
        start_test("taken_slot1", 1'b1, 32'h0);
        end_test();
    endtask

    task automatic test_redirect();
        fill_mem();
        start_test("redirect", 1'b0, 32'h100);
        // One pair sits in the buffer when the redirect hits
        while (!slot0_valid_o) begin
            @(posedge clk);
        end
        while (!(req_valid_o && req_ready_i)) begin
            @(posedge clk);
        end
        redirect_i    <= 1'b1;
        redirect_pc_i <= 32'h100;
        @(posedge clk);
        redirect_i    <= 1'b0;
        issue_ready_i <= 1'b1;
        @(posedge clk);
        if (slot0_valid_o || slot1_valid_o) begin
            $display("%s: slots still valid after the redirect", cur_test);
            test_err++;
        end
        while (!(req_valid_o && req_ready_i)) begin
            @(posedge clk);
        end
        check_pc(32'h100, req_pc_o);
        end_test();
    endtask

    initial begin
        seed          = 77;
        cycles        = 0;
        total_err     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        cur_test      = "init";
        rst_n_i       = 1'b0;
        req_ready_i   = 1'b0;
        resp_valid_i  = 1'b0;
        resp_inst0_i  = '0;
        resp_inst1_i  = '0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        issue_ready_i = 1'b0;
        test_sequential();
        test_backpressure();
        test_forward_branch();
        test_taken_slot0();
        test_taken_slot1();
        test_redirect();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_err);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* fetch.f */
hw/fetch_pkg.sv
hw/fetch_pc_gen.sv
hw/fetch_predecode.sv
hw/inst_buffer.sv
hw/fetch_top.sv
tb/fetch_props.sv
tb/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module fetch_tb \
    -f fetch.f \
    -o fetch_sim

if ! ./obj_dir/fetch_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
